/* logic/sdhc_consts.svh */
`ifndef SDHC_CONSTS_SVH
`define SDHC_CONSTS_SVH

`define SDHC_ADDR_W 12
`define SDHC_DATA_W 32
`define SDHC_IRQ_W  16 // one status half

// register offsets
`define ADDR_BLK_SIZE  12'h004
`define ADDR_BLK_COUNT 12'h006
`define ADDR_ARGUMENT  12'h008
`define ADDR_XFER_MODE 12'h00A
`define ADDR_COMMAND   12'h00E
`define ADDR_RESPONSE  12'h010 // read only
`define ADDR_PRESENT   12'h024 // read only
`define ADDR_NORM_INT  12'h030
`define ADDR_ERR_INT   12'h032
`define ADDR_INT_EN    12'h038

// normal status bits
`define IRQ_CMD_DONE  0
`define IRQ_XFER_DONE 1

`endif

/* logic/sdhc_pkg.sv */
`include "sdhc_consts.svh"

package sdhc_pkg;

	typedef logic [`SDHC_ADDR_W-1:0] reg_addr_t;
	typedef logic [`SDHC_DATA_W-1:0] reg_word_t;
	typedef logic [`SDHC_IRQ_W-1:0]  irq_half_t;

	// decoded register
	typedef enum logic [3:0] {
		SEL_BLK_SIZE,
		SEL_BLK_COUNT,
		SEL_ARGUMENT,
		SEL_XFER_MODE,
		SEL_COMMAND,
		SEL_RESPONSE,
		SEL_PRESENT,
		SEL_NORM_INT,
		SEL_ERR_INT,
		SEL_INT_EN,
		SEL_NONE
	} reg_sel_e;

endpackage

/* logic/host_req_decode.sv */
`include "sdhc_consts.svh"

module host_req_decode import sdhc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      req,
	input  logic      wr_valid,
	input  reg_addr_t addr,
	input  reg_word_t wr_data,
	output logic      s1_valid,
	output logic      s1_write,
	output reg_sel_e  s1_sel,
	output reg_word_t s1_data
);

	reg_sel_e sel;

	always_comb begin
		case (addr)
			`ADDR_BLK_SIZE:  sel = SEL_BLK_SIZE;
			`ADDR_BLK_COUNT: sel = SEL_BLK_COUNT;
			`ADDR_ARGUMENT:  sel = SEL_ARGUMENT;
			`ADDR_XFER_MODE: sel = SEL_XFER_MODE;
			`ADDR_COMMAND:   sel = SEL_COMMAND;
			`ADDR_NORM_INT:  sel = SEL_NORM_INT;
			`ADDR_ERR_INT:   sel = SEL_ERR_INT;
			`ADDR_INT_EN:    sel = SEL_INT_EN;
			// core-owned, so a write here is an address error
			`ADDR_RESPONSE: begin
				if (wr_valid)
					sel = SEL_NONE;
				else
					sel = SEL_RESPONSE;
			end
			`ADDR_PRESENT: begin
				if (wr_valid)
					sel = SEL_NONE;
				else
					sel = SEL_PRESENT;
			end
			default:         sel = SEL_NONE; // outside the map
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_write <= 1'b0;
			s1_sel   <= SEL_NONE;
			s1_data  <= '0;
		end else begin
			s1_valid <= req;
			s1_write <= req & wr_valid;
			if (req) begin
				s1_sel  <= sel;
				s1_data <= wr_data;
			end else begin
				s1_sel  <= SEL_NONE;
				s1_data <= '0;
			end
		end
	end

endmodule

/* logic/sdhc_reg_bank.sv */
`include "sdhc_consts.svh"

module sdhc_reg_bank import sdhc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      s1_valid,
	input  logic      s1_write,
	input  reg_sel_e  s1_sel,
	input  reg_word_t s1_data,
	input  reg_word_t resp_data,
	input  reg_word_t present_state,
	input  irq_half_t norm_status,
	input  irq_half_t err_status,
	input  irq_half_t int_en,
	output reg_word_t blk_size,
	output reg_word_t blk_count,
	output reg_word_t argument,
	output reg_word_t xfer_mode,
	output reg_word_t command,
	output logic      cmd_start,
	output irq_half_t norm_clr,
	output irq_half_t err_clr,
	output logic      int_en_wr,
	output irq_half_t int_en_data,
	output logic      s2_valid,
	output reg_word_t s2_rdata,
	output logic      s2_err
);

	logic      wr_hit;
	logic      rd_hit;
	reg_word_t rd_word;

	assign wr_hit = s1_valid & s1_write;
	assign rd_hit = s1_valid & ~s1_write;

	// status clears and enable writes land at the same edge as register writes
	assign norm_clr    = (wr_hit && s1_sel == SEL_NORM_INT) ? s1_data[`SDHC_IRQ_W-1:0] : '0;
	assign err_clr     = (wr_hit && s1_sel == SEL_ERR_INT) ? s1_data[`SDHC_IRQ_W-1:0] : '0;
	assign int_en_wr   = wr_hit && s1_sel == SEL_INT_EN;
	assign int_en_data = s1_data[`SDHC_IRQ_W-1:0];

	always_comb begin
		case (s1_sel)
			SEL_BLK_SIZE:  rd_word = blk_size;
			SEL_BLK_COUNT: rd_word = blk_count;
			SEL_ARGUMENT:  rd_word = argument;
			SEL_XFER_MODE: rd_word = xfer_mode;
			SEL_COMMAND:   rd_word = command;
			SEL_RESPONSE:  rd_word = resp_data;
			SEL_PRESENT:   rd_word = present_state;
			SEL_NORM_INT:  rd_word = reg_word_t'(norm_status); // zero extended
			SEL_ERR_INT:   rd_word = reg_word_t'(err_status);
			SEL_INT_EN:    rd_word = reg_word_t'(int_en);
			default:       rd_word = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blk_size  <= '0;
			blk_count <= '0;
			argument  <= '0;
			xfer_mode <= '0;
			command   <= '0;
			cmd_start <= 1'b0;
		end else begin
			cmd_start <= 1'b0; // single cycle
			if (wr_hit) begin
				case (s1_sel)
					SEL_BLK_SIZE:  blk_size  <= s1_data;
					SEL_BLK_COUNT: blk_count <= s1_data;
					SEL_ARGUMENT:  argument  <= s1_data;
					SEL_XFER_MODE: xfer_mode <= s1_data;
					SEL_COMMAND: begin
						command   <= s1_data;
						cmd_start <= 1'b1; // launch
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
			s2_rdata <= '0;
			s2_err   <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
			s2_err   <= s1_valid && s1_sel == SEL_NONE;
			s2_rdata <= rd_hit ? rd_word : '0; // writes return zero
		end
	end

endmodule

/* logic/sdhc_irq_status.sv */
`include "sdhc_consts.svh"

module sdhc_irq_status import sdhc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cmd_done,
	input  logic      xfer_done,
	input  irq_half_t err_events,
	input  irq_half_t norm_clr,
	input  irq_half_t err_clr,
	input  logic      int_en_wr,
	input  irq_half_t int_en_data,
	output irq_half_t norm_status,
	output irq_half_t err_status,
	output irq_half_t int_en,
	output logic      irq
);

	localparam int EN_HALF = `SDHC_IRQ_W / 2;

	irq_half_t norm_set;
	logic      norm_pend;
	logic      err_pend;

	always_comb begin
		norm_set                 = '0;
		norm_set[`IRQ_CMD_DONE]  = cmd_done;
		norm_set[`IRQ_XFER_DONE] = xfer_done;
	end

	// low enable byte for normal bits, high byte for error bits 0..7
	assign norm_pend = |(norm_status[EN_HALF-1:0] & int_en[EN_HALF-1:0]);
	assign err_pend  = |(err_status[EN_HALF-1:0] & int_en[`SDHC_IRQ_W-1:EN_HALF]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			norm_status <= '0;
			err_status  <= '0;
		end else begin
			// set wins over a clear at the same edge
			norm_status <= (norm_status & ~norm_clr) | norm_set;
			err_status  <= (err_status & ~err_clr) | err_events;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			int_en <= '0;
		else if (int_en_wr)
			int_en <= int_en_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq <= 1'b0;
		else
			irq <= norm_pend | err_pend; // one cycle behind status
	end

endmodule

/* logic/host_resp_stage.sv */
module host_resp_stage import sdhc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      s2_valid,
	input  reg_word_t s2_rdata,
	input  logic      s2_err,
	output logic      ack,
	output reg_word_t rd_data,
	output logic      addr_err
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack      <= 1'b0;
			rd_data  <= '0;
			addr_err <= 1'b0;
		end else begin
			ack <= s2_valid;
			if (s2_valid) begin
				addr_err <= s2_err;
				// errored accesses return no data
				if (s2_err)
					rd_data <= '0;
				else
					rd_data <= s2_rdata;
			end else begin
				addr_err <= 1'b0;
				rd_data  <= '0;
			end
		end
	end

endmodule

/* logic/sdhc_regif_top.sv */
module sdhc_regif_top import sdhc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      req,
	input  logic      wr_valid,
	input  reg_addr_t addr,
	input  reg_word_t wr_data,
	output reg_word_t rd_data,
	output logic      ack,
	output logic      addr_err,
	output reg_word_t blk_size,
	output reg_word_t blk_count,
	output reg_word_t argument,
	output reg_word_t xfer_mode,
	output reg_word_t command,
	output logic      cmd_start,
	output logic      irq,
	input  reg_word_t resp_data,
	input  reg_word_t present_state,
	input  logic      cmd_done,
	input  logic      xfer_done,
	input  irq_half_t err_events
);

	logic      s1_valid;
	logic      s1_write;
	reg_sel_e  s1_sel;
	reg_word_t s1_data;

	logic      s2_valid;
	reg_word_t s2_rdata;
	logic      s2_err;

	irq_half_t norm_clr;
	irq_half_t err_clr;
	logic      int_en_wr;
	irq_half_t int_en_data;
	irq_half_t norm_status;
	irq_half_t err_status;
	irq_half_t int_en;

	host_req_decode i_host_req_decode (
		.clk, .rst_n, .req, .wr_valid, .addr, .wr_data,
		.s1_valid, .s1_write, .s1_sel, .s1_data
	);

	sdhc_reg_bank i_sdhc_reg_bank (
		.clk, .rst_n, .s1_valid, .s1_write, .s1_sel, .s1_data,
		.resp_data, .present_state, .norm_status, .err_status, .int_en,
		.blk_size, .blk_count, .argument, .xfer_mode, .command, .cmd_start,
		.norm_clr, .err_clr, .int_en_wr, .int_en_data,
		.s2_valid, .s2_rdata, .s2_err
	);

	sdhc_irq_status i_sdhc_irq_status (
		.clk, .rst_n, .cmd_done, .xfer_done, .err_events,
		.norm_clr, .err_clr, .int_en_wr, .int_en_data,
		.norm_status, .err_status, .int_en, .irq
	);

	host_resp_stage i_host_resp_stage (
		.clk, .rst_n, .s2_valid, .s2_rdata, .s2_err,
		.ack, .rd_data, .addr_err
	);

endmodule

/* test/sdhc_regif_sva.sv */
module sdhc_regif_sva (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic ack,
	input logic addr_err,
	input logic cmd_start,
	input logic irq
);

	timeunit 1ns;
	timeprecision 1ps;

	// fixed latency, so ack is req delayed by three edges
	ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
		ack == $past(req, 3))
		else $error("ack is not req delayed by three cycles");

	cmd_then_ack: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_start |=> ack)
		else $error("cmd_start not followed by ack");

	err_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
		addr_err |-> ack)
		else $error("addr_err without ack");

	reset_quiet: assert property (@(posedge clk)
		!rst_n |-> !ack && !addr_err && !cmd_start && !irq)
		else $error("control output active during reset");

endmodule

bind sdhc_regif_top sdhc_regif_sva i_sdhc_regif_sva (.*);

/* test/sdhc_regif_tb.sv */
`include "sdhc_consts.svh"

module sdhc_regif_tb import sdhc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic      write;
		reg_addr_t addr;
		reg_word_t data;
		logic      err;
		int        due;
	} exp_resp_t;

	logic      clk;
	logic      rst_n;
	logic      req;
	logic      wr_valid;
	reg_addr_t addr;
	reg_word_t wr_data;
	reg_word_t rd_data;
	logic      ack;
	logic      addr_err;
	reg_word_t blk_size;
	reg_word_t blk_count;
	reg_word_t argument;
	reg_word_t xfer_mode;
	reg_word_t command;
	logic      cmd_start;
	logic      irq;
	reg_word_t resp_data;
	reg_word_t present_state;
	logic      cmd_done;
	logic      xfer_done;
	irq_half_t err_events;

	logic [3:0] pat_op[$];
	reg_addr_t  pat_addr[$];
	reg_word_t  pat_data[$];
	logic       pat_err[$];
	exp_resp_t  exp_q[$];
	int         cmd_due_q[$];
	reg_word_t  cmd_val_q[$];
	int         cycle;
	int         cycle_limit;
	integer     seed;
	reg_word_t  resp_val;
	reg_word_t  pres_val;

	sdhc_regif_top i_sdhc_regif_top (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic end_with_fail();
		$display("RESULT: FAIL");
		$fatal(1, "run stopped on the first error");
	endtask

	task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
		assert (got === exp) else begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			end_with_fail();
		end
	endtask

	// the core-side copy of a writable register
	task automatic check_core_reg(input reg_addr_t a, input reg_word_t exp);
		case (a)
			`ADDR_BLK_SIZE:  check_word("blk_size", blk_size, exp);
			`ADDR_BLK_COUNT: check_word("blk_count", blk_count, exp);
			`ADDR_ARGUMENT:  check_word("argument", argument, exp);
			`ADDR_XFER_MODE: check_word("xfer_mode", xfer_mode, exp);
			`ADDR_COMMAND:   check_word("command", command, exp);
			default: ;
		endcase
	endtask

	task automatic load_patterns();
		int         fd;
		int         n;
		string      line;
		logic [3:0] op;
		reg_addr_t  a;
		reg_word_t  d;
		logic       e;
		fd = $fopen("test/sdhc_regif_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open the pattern file");
			end_with_fail();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h", op, a, d, e);
			if (n != 4) begin
				$display("malformed pattern line: %s", line);
				end_with_fail();
			end
			pat_op.push_back(op);
			pat_addr.push_back(a);
			pat_data.push_back(d);
			pat_err.push_back(e);
		end
		$fclose(fd);
	endtask

	task automatic drive_quiet();
		req        <= 1'b0;
		cmd_done   <= 1'b0;
		xfer_done  <= 1'b0;
		err_events <= '0;
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle > cycle_limit) begin
			$display("timeout after %0d cycles", cycle);
			end_with_fail();
		end
	end

	// responses and command pulses, sampled mid-cycle
	always @(negedge clk) begin
		exp_resp_t ent;
		int        due_c;
		if (rst_n) begin
			if (ack) begin
				if (exp_q.size() == 0) begin
					$display("ack seen with no request pending");
					end_with_fail();
				end
				ent = exp_q.pop_front();
				assert (ent.due == cycle) else begin
					$display("ack came in cycle %0d instead of cycle %0d", cycle, ent.due);
					end_with_fail();
				end
				check_word("addr_err", reg_word_t'(addr_err), reg_word_t'(ent.err));
				check_word("rd_data", rd_data, (ent.write || ent.err) ? '0 : ent.data);
				if (!ent.write && !ent.err)
					check_core_reg(ent.addr, ent.data);
			end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
				$display("no ack for the request due in cycle %0d", exp_q[0].due);
				end_with_fail();
			end
			if (cmd_start) begin
				if (cmd_due_q.size() == 0) begin
					$display("cmd_start pulse without a command write");
					end_with_fail();
				end
				due_c = cmd_due_q.pop_front();
				assert (due_c == cycle) else begin
					$display("cmd_start in cycle %0d instead of cycle %0d", cycle, due_c);
					end_with_fail();
				end
				check_word("command", command, cmd_val_q.pop_front());
			end else if (cmd_due_q.size() != 0 && cmd_due_q[0] <= cycle) begin
				$display("missing cmd_start for a command write");
				end_with_fail();
			end
		end
	end

	initial begin
		exp_resp_t ent;
		int        i;
		seed          = 58934;
		cycle         = 0;
		rst_n         = 1'b0;
		req           = 1'b0;
		wr_valid      = 1'b0;
		addr          = '0;
		wr_data       = '0;
		cmd_done      = 1'b0;
		xfer_done     = 1'b0;
		err_events    = '0;
		resp_val      = $random(seed);
		pres_val      = $random(seed);
		resp_data     = resp_val;
		present_state = pres_val;
		load_patterns();
		cycle_limit = pat_op.size() * 4 + 20;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_word("blk_size", blk_size, '0);
		check_word("blk_count", blk_count, '0);
		check_word("argument", argument, '0);
		check_word("xfer_mode", xfer_mode, '0);
		check_word("command", command, '0);
		check_word("rd_data", rd_data, '0);
		for (i = 0; i < pat_op.size(); i++) begin
			@(posedge clk);
			drive_quiet();
			case (pat_op[i])
				4'h1, 4'h2: begin
					req       <= 1'b1;
					wr_valid  <= pat_op[i] == 4'h1;
					addr      <= pat_addr[i];
					wr_data   <= (pat_op[i] == 4'h1) ? pat_data[i] : '0;
					ent.write = pat_op[i] == 4'h1;
					ent.addr  = pat_addr[i];
					ent.data  = pat_data[i];
					ent.err   = pat_err[i];
					ent.due   = cycle + 4; // req is high in cycle + 1
					if (!ent.write && pat_addr[i] == `ADDR_RESPONSE)
						ent.data = resp_val;
					if (!ent.write && pat_addr[i] == `ADDR_PRESENT)
						ent.data = pres_val;
					exp_q.push_back(ent);
					if (ent.write && pat_addr[i] == `ADDR_COMMAND) begin
						cmd_due_q.push_back(cycle + 3);
						cmd_val_q.push_back(pat_data[i]);
					end
				end
				4'h3: begin
					cmd_done   <= pat_addr[i][0];
					xfer_done  <= pat_addr[i][1];
					err_events <= pat_data[i][15:0];
				end
				4'h4: begin
					@(negedge clk);
					check_word("irq", reg_word_t'(irq), reg_word_t'(pat_data[i][0]));
				end
				default: begin
					// new core values only while nothing is in flight
					if (exp_q.size() == 0) begin
						resp_val      = $random(seed);
						pres_val      = $random(seed);
						resp_data     <= resp_val;
						present_state <= pres_val;
					end
				end
			endcase
		end
		@(posedge clk);
		drive_quiet();
		repeat (4) @(posedge clk);
		if (exp_q.size() == 0 && cmd_due_q.size() == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("requests still waiting for a response at the end");
			end_with_fail();
		end
	end

endmodule

/* test/sdhc_regif_patterns.txt */
# op addr data err, hex; op 0 idle, 1 write, 2 read, 3 event, 4 expect irq (data bit 0)
# event: addr bit 0 cmd_done, bit 1 xfer_done, data err_events; reads of 010/024 expect core inputs
1 004 00000200 0
1 006 00000010 0
1 008 12345678 0
1 00a 00000023 0
2 004 00000200 0
2 006 00000010 0
2 008 12345678 0
2 00a 00000023 0
1 00e 0000113a 0
1 00e 00000c52 0
2 00e 00000c52 0
1 008 cafef00d 0
2 008 cafef00d 0
1 010 ffffffff 1
1 024 ffffffff 1
1 00c 0000ffff 1
2 100 00000000 1
2 004 00000200 0
3 001 00000000 0
1 038 00000001 0
4 000 00000000 0
0 000 00000000 0
4 000 00000001 0
3 002 00000000 0
1 030 00000001 0
3 000 00000005 0
2 030 00000002 0
1 038 00000401 0
4 000 00000000 0
2 032 00000005 0
4 000 00000001 0
1 032 00000005 0
3 000 00000004 0
2 038 00000401 0
2 032 00000004 0
1 032 00000004 0
2 030 00000002 0
0 000 00000000 0
4 000 00000000 0
2 032 00000000 0
0 000 00000000 0
0 000 00000000 0
0 000 00000000 0
0 000 00000000 0
2 010 00000000 0
2 024 00000000 0

/* sources.f */
+incdir+logic
logic/sdhc_pkg.sv
logic/host_req_decode.sv
logic/sdhc_reg_bank.sv
logic/sdhc_irq_status.sv
logic/host_resp_stage.sv
logic/sdhc_regif_top.sv
test/sdhc_regif_sva.sv
test/sdhc_regif_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the register interface testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module sdhc_regif_tb -Mdir obj_dir -o sdhc_regif_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sdhc_regif_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$log"; then
	exit 0
else
	echo "pass message not found in $log"
	exit 1
fi
